//--- Bender.yml
package:
  name: vector_sequencer

sources:
  - src/seq_pkg.sv
  - src/vid_tracker.sv
  - src/vreg_hazard_checker.sv
  - src/unit_queue_counters.sv
  - src/issue_fsm.sv
  - src/vector_sequencer.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_vector_sequencer.sv

//--- sim/seq_stim.txt
# REQ op vd use_vd vs2 use_vs2 operand use_vs1 use_scalar vm unit id hvs1 hvs2 hvm hvd stall
# BLOCK op vd use_vd vs2 use_vs2 operand use_vs1 use_scalar vm cycles, DONE unit mask, ACK err vl
CHK_IDLE 1
REQ 0 01 1 02 1 0003 1 0 1 0 0 00 00 00 00 0
CHK_IDLE 0
REQ 3 04 1 01 1 0005 1 0 1 1 1 00 01 00 00 0
REQ 1 07 1 06 1 0001 1 1 1 0 2 00 00 00 00 0
REQ 0 00 1 09 1 000a 1 0 1 0 3 00 00 00 00 0
REQ 2 0b 1 0c 1 000d 1 0 0 0 4 00 00 08 00 0
CHK_TABLE 1 01
CHK_TABLE 4 08
REQ 4 05 1 0e 1 000f 1 0 1 1 5 02 02 02 00 0
REQ 3 04 1 10 1 0011 1 0 1 1 6 00 00 00 02 0
CHK_TABLE 5 02
CHK_TABLE 6 02
BLOCK 1 12 1 13 1 0014 1 0 1 4
DONE 0 01
REQ 1 12 1 13 1 0014 1 0 1 0 0 00 00 00 00 1
CHK_TABLE 1 00
REQ 5 15 1 00 0 0000 0 0 1 2 7 00 00 00 00 0
ACK 1 0005
DONE 2 80
BLOCK 5 04 1 00 0 0000 0 0 1 3
DONE 1 40
REQ 5 04 1 00 0 0000 0 0 1 2 6 00 00 00 00 0
ACK 0 0000
REQ 6 00 0 05 1 0000 0 0 1 3 7 00 20 00 00 0
ACK 0 0123
CHK_TABLE 7 20
DONE 3 80
REQ 9 00 0 0b 1 0000 0 0 1 4 7 00 10 00 00 0
SCAL deadbeef
CHK_TABLE 7 10
DONE 0 01
DONE 0 04
DONE 0 08
DONE 0 10
CHK_TABLE 7 00
DONE 1 02
DONE 1 20
DONE 2 40
DONE 4 80
CHK_IDLE 1

//--- sim/tb_checks.svh
/*
 * Testbench compare tasks
 * Typed checks for requests, answers, ID masks and single bits,
 * with the check and error counters
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int unsigned check_count = 0;
int unsigned error_count = 0;

// Whole processing-unit request, hazards included
task automatic compare_pe_req(input pe_req_t exp, input pe_req_t act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("Fail pe_req_o expected %h actual %h", exp, act);
  end
endtask

// Answer to the dispatcher
task automatic compare_resp(input seq_resp_t exp, input seq_resp_t act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("Fail seq_resp_o expected %h actual %h", exp, act);
  end
endtask

// Hazard vectors and table rows
task automatic compare_vmask(input string name, input vmask_t exp, input vmask_t act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("Fail %s expected %h actual %h", name, exp, act);
  end
endtask

task automatic compare_bit(input string name, input logic exp, input logic act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("Fail %s expected %h actual %h", name, exp, act);
  end
endtask

`endif

//--- sim/tb_vector_sequencer.sv
/*
 * Vector sequencer testbench
 * Clock, reset, processing-unit model, stimulus reader and watchdog
 */
`timescale 1ns/1ps

module tb_vector_sequencer;
  import seq_pkg::*;

  localparam int ClkHalf   = 20;
  localparam int WaitLimit = 100;

  logic                 clk_i;
  logic                 rst_ni;
  seq_req_t             seq_req;
  logic                 seq_req_valid, seq_req_ready;
  seq_resp_t            seq_resp;
  logic                 seq_resp_valid;
  pe_req_t              pe_req;
  logic                 pe_req_valid, pe_req_ready;
  vmask_t [NrUnits-1:0] pe_done;
  logic                 addrgen_ack, addrgen_error;
  logic [15:0]          addrgen_error_vl;
  logic [31:0]          scalar_resp;
  logic                 scalar_resp_valid, scalar_resp_ready;
  logic                 seq_idle;
  vmask_t               running;
  vmask_t [NrVInsn-1:0] hazard_table;

  // IDs issued and not yet reported done
  vmask_t         exp_running;

  integer         seed = 32'h2f81_4406;
  int             fd;
  int             stim_lines = 0;
  int             test_count = 0;
  int unsigned    errors_before;
  logic [31:0]    f [0:15];
  reg [8*12-1:0]  cmd;
  reg [8*256-1:0] line_buf;

  `include "tb_checks.svh"

  always #(ClkHalf) clk_i = ~clk_i;

  vector_sequencer u_vector_sequencer (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .seq_req_i (seq_req), .seq_req_valid_i (seq_req_valid), .seq_req_ready_o (seq_req_ready),
    .seq_resp_o (seq_resp), .seq_resp_valid_o (seq_resp_valid),
    .pe_req_o (pe_req), .pe_req_valid_o (pe_req_valid), .pe_req_ready_i (pe_req_ready),
    .pe_done_i (pe_done),
    .addrgen_ack_i (addrgen_ack), .addrgen_error_i (addrgen_error),
    .addrgen_error_vl_i (addrgen_error_vl),
    .scalar_resp_i (scalar_resp), .scalar_resp_valid_i (scalar_resp_valid),
    .scalar_resp_ready_o (scalar_resp_ready),
    .seq_idle_o (seq_idle), .running_o (running), .global_hazard_table_o (hazard_table)
  );

  ////////////////////
  // Dispatcher side
  ////////////////////

  // Request fields in file order
  task automatic load_req();
    seq_req.op          = op_e'(f[0][3:0]);
    seq_req.vd          = vreg_t'(f[1]);
    seq_req.use_vd      = f[2][0];
    seq_req.vs2         = vreg_t'(f[3]);
    seq_req.use_vs2     = f[4][0];
    seq_req.operand.imm = f[5][15:0];
    seq_req.use_vs1     = f[6][0];
    seq_req.use_scalar  = f[7][0];
    seq_req.vm          = f[8][0];
  endtask

  task automatic issue_request();
    pe_req_t exp;
    int      waited;
    int      stall_cycles;
    logic    answered;
    load_req();
    seq_req_valid = 1'b1;
    pe_req_ready  = ~f[15][0];
    // Loads, stores and the scalar move keep the request until the answer
    answered = (f[9] == 2) || (f[9] == 3) || (f[0] == 9);
    exp = '{id: vid_t'(f[10]), op: seq_req.op, unit: unit_e'(f[9][2:0]),
            vd: seq_req.vd, use_vd: seq_req.use_vd, vs2: seq_req.vs2,
            use_vs2: seq_req.use_vs2, operand: seq_req.operand, use_vs1: seq_req.use_vs1,
            use_scalar: seq_req.use_scalar, vm: seq_req.vm,
            hazard_vs1: vmask_t'(f[11]), hazard_vs2: vmask_t'(f[12]),
            hazard_vm: vmask_t'(f[13]), hazard_vd: vmask_t'(f[14])};
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!pe_req_valid && waited < WaitLimit);
    if (!pe_req_valid) begin
      error_count++;
      $display("Request was never issued to the processing units");
    end else begin
      compare_pe_req(exp, pe_req);
      exp_running[f[10][2:0]] = 1'b1;
      if (answered) compare_bit("seq_resp_valid_o", 1'b0, seq_resp_valid);
      else seq_req_valid = 1'b0;
      if (f[15][0]) begin
        stall_cycles = 1 + ($unsigned($random(seed)) % 4);
        repeat (stall_cycles) begin
          @(negedge clk_i);
          compare_bit("pe_req_valid_o", 1'b1, pe_req_valid);
          compare_bit("seq_req_ready_o", 1'b0, seq_req_ready);
          compare_pe_req(exp, pe_req);
        end
        pe_req_ready = 1'b1;
        @(negedge clk_i);
        compare_bit("pe_req_valid_o", 1'b0, pe_req_valid);
      end
    end
  endtask

  // Request must sit on the port without being issued
  task automatic expect_blocked();
    load_req();
    seq_req_valid = 1'b1;
    repeat (f[9]) begin
      @(negedge clk_i);
      compare_bit("pe_req_valid_o", 1'b0, pe_req_valid);
      compare_bit("seq_req_ready_o", 1'b0, seq_req_ready);
    end
  endtask

  // Answer is combinational and sampled mid low phase
  task automatic ack_memory_op();
    seq_resp_t exp;
    exp = '{resp: 32'h0, error: f[0][0], error_vl: f[1][15:0]};
    compare_bit("seq_resp_valid_o", 1'b0, seq_resp_valid);
    addrgen_ack      = 1'b1;
    addrgen_error    = f[0][0];
    addrgen_error_vl = f[1][15:0];
    #(ClkHalf / 2);
    compare_bit("seq_resp_valid_o", 1'b1, seq_resp_valid);
    compare_bit("seq_req_ready_o", 1'b1, seq_req_ready);
    compare_resp(exp, seq_resp);
    @(negedge clk_i);
    addrgen_ack   = 1'b0;
    seq_req_valid = 1'b0;
  endtask

  task automatic return_scalar();
    seq_resp_t exp;
    exp = '{resp: f[0], error: 1'b0, error_vl: 16'h0};
    compare_bit("seq_resp_valid_o", 1'b0, seq_resp_valid);
    scalar_resp       = f[0];
    scalar_resp_valid = 1'b1;
    #(ClkHalf / 2);
    compare_bit("seq_resp_valid_o", 1'b1, seq_resp_valid);
    compare_bit("scalar_resp_ready_o", 1'b1, scalar_resp_ready);
    compare_resp(exp, seq_resp);
    @(negedge clk_i);
    scalar_resp_valid = 1'b0;
    seq_req_valid     = 1'b0;
  endtask

  ////////////////////
  // Processing-unit model
  ////////////////////

  // One cycle of completions on one unit
  task automatic pulse_done();
    pe_done[f[0][2:0]] = vmask_t'(f[1]);
    @(negedge clk_i);
    pe_done = '0;
    exp_running &= ~vmask_t'(f[1]);
  endtask

  // Limit starts once the stimulus is counted and reset is released
  initial begin
    wait (rst_ni === 1'b1);
    repeat (stim_lines * 50 + 200) @(posedge clk_i);
    $display("Run timed out before the stimulus was finished");
    $display("test failed");
    $finish;
  end

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    seq_req = '0;
    seq_req_valid = 1'b0;
    pe_req_ready = 1'b1;
    pe_done = '0;
    addrgen_ack = 1'b0;
    addrgen_error = 1'b0;
    addrgen_error_vl = '0;
    scalar_resp = '0;
    scalar_resp_valid = 1'b0;
    exp_running = '0;
    fd = $fopen("sim/seq_stim.txt", "r");
    if (fd == 0) begin
      error_count++;
      $display("Could not open the stimulus file");
    end else begin
      // Size of the run for the watchdog
      while ($fgets(line_buf, fd)) stim_lines++;
      $fclose(fd);
      fd = $fopen("sim/seq_stim.txt", "r");
      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      rst_ni = 1'b1;
      while ($fscanf(fd, "%s", cmd) == 1) begin
        if (cmd == "#") begin
          void'($fgets(line_buf, fd));
        end else begin
          errors_before = error_count;
          if (cmd == "REQ") begin
            void'($fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                          f[9], f[10], f[11], f[12], f[13], f[14], f[15]));
            issue_request();
          end else if (cmd == "BLOCK") begin
            void'($fscanf(fd, "%h %h %h %h %h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]));
            expect_blocked();
          end else if (cmd == "DONE") begin
            void'($fscanf(fd, "%h %h", f[0], f[1]));
            pulse_done();
          end else if (cmd == "ACK") begin
            void'($fscanf(fd, "%h %h", f[0], f[1]));
            ack_memory_op();
          end else if (cmd == "SCAL") begin
            void'($fscanf(fd, "%h", f[0]));
            return_scalar();
          end else if (cmd == "CHK_TABLE") begin
            void'($fscanf(fd, "%h %h", f[0], f[1]));
            compare_vmask($sformatf("global_hazard_table_o[%0d]", f[0]),
                          vmask_t'(f[1]), hazard_table[f[0][2:0]]);
          end else if (cmd == "CHK_IDLE") begin
            void'($fscanf(fd, "%h", f[0]));
            compare_bit("seq_idle_o", f[0][0], seq_idle);
          end else begin
            error_count++;
            $display("Unknown command in the stimulus file");
          end
          // Running IDs follow issues and completions
          compare_vmask("running_o", exp_running, running);
          test_count++;
          $display("Test %0d %0s: %0s", test_count, cmd,
                   (error_count == errors_before) ? "ok" : "errors");
        end
      end
      $fclose(fd);
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+sim
src/seq_pkg.sv
src/vid_tracker.sv
src/vreg_hazard_checker.sv
src/unit_queue_counters.sv
src/issue_fsm.sv
src/vector_sequencer.sv
sim/tb_vector_sequencer.sv

//--- src/issue_fsm.sv
/*
 * Issue FSM
 * Accepts dispatcher requests, issues them to the processing units,
 * holds stalled requests and waits for the answer of loads, stores
 * and scalar moves
 */
`timescale 1ns/1ps

module issue_fsm (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Dispatcher
  input  seq_pkg::seq_req_t           seq_req_i,
  input  logic                        seq_req_valid_i,
  output logic                        seq_req_ready_o,
  output seq_pkg::seq_resp_t          seq_resp_o,
  output logic                        seq_resp_valid_o,
  // Processing units
  output seq_pkg::pe_req_t            pe_req_o,
  output logic                        pe_req_valid_o,
  input  logic                        pe_req_ready_i,
  // Hazards of the current request
  input  seq_pkg::vmask_t             hazard_vs1_i,
  input  seq_pkg::vmask_t             hazard_vs2_i,
  input  seq_pkg::vmask_t             hazard_vm_i,
  input  seq_pkg::vmask_t             hazard_vd_i,
  // ID and queue status
  input  seq_pkg::vid_t               next_vid_i,
  input  logic                        vid_full_i,
  input  logic [seq_pkg::NrUnits-1:0] unit_room_i,
  output logic                        issue_o,
  output seq_pkg::vid_t               issue_vid_o,
  output seq_pkg::unit_e              issue_unit_o,
  // Address generator
  input  logic                        addrgen_ack_i,
  input  logic                        addrgen_error_i,
  input  logic [15:0]                 addrgen_error_vl_i,
  // Scalar response of the slide unit
  input  logic [31:0]                 scalar_resp_i,
  input  logic                        scalar_resp_valid_i,
  output logic                        scalar_resp_ready_o
);
  import seq_pkg::*;

  enum logic {IDLE, WAIT} state_d, state_q;

  pe_req_t pe_req_d;
  logic    pe_req_valid_d;
  logic    stalled;
  logic    no_vec_src;
  logic    any_hazard;
  logic    can_issue;
  logic    needs_answer;

  assign issue_vid_o  = next_vid_i;
  assign issue_unit_o = unit_of(seq_req_i.op);

  // Previous request not yet taken by the units
  assign stalled = pe_req_valid_o & ~pe_req_ready_i;

  // Ops without vector sources and mask issue only hazard free
  assign no_vec_src = ~(seq_req_i.use_vs1 & ~seq_req_i.use_scalar) &
                      ~seq_req_i.use_vs2 & seq_req_i.vm;
  assign any_hazard = |{hazard_vs1_i, hazard_vs2_i, hazard_vm_i, hazard_vd_i};

  assign can_issue = seq_req_valid_i & ~stalled & ~vid_full_i &
                     unit_room_i[issue_unit_o] & ~(no_vec_src & any_hazard);

  // Loads, stores and the scalar move answer the dispatcher
  assign needs_answer = (issue_unit_o == UNIT_LOAD) | (issue_unit_o == UNIT_STORE) |
                        (seq_req_i.op == VMVXS);

  always_comb begin
    state_d             = state_q;
    pe_req_d            = pe_req_o;
    // Keep a stalled request, drop a consumed one
    pe_req_valid_d      = stalled;
    seq_req_ready_o     = 1'b0;
    seq_resp_o          = '0;
    seq_resp_valid_o    = 1'b0;
    scalar_resp_ready_o = 1'b0;
    issue_o             = 1'b0;

    unique case (state_q)
      IDLE: begin
        seq_req_ready_o = ~stalled;
        if (seq_req_valid_i) begin
          seq_req_ready_o = can_issue & ~needs_answer;
          if (can_issue) begin
            issue_o        = 1'b1;
            pe_req_valid_d = 1'b1;
            pe_req_d       = '{
              id:         next_vid_i,
              op:         seq_req_i.op,
              unit:       issue_unit_o,
              vd:         seq_req_i.vd,
              use_vd:     seq_req_i.use_vd,
              vs2:        seq_req_i.vs2,
              use_vs2:    seq_req_i.use_vs2,
              operand:    seq_req_i.operand,
              use_vs1:    seq_req_i.use_vs1,
              use_scalar: seq_req_i.use_scalar,
              vm:         seq_req_i.vm,
              hazard_vs1: hazard_vs1_i,
              hazard_vs2: hazard_vs2_i,
              hazard_vm:  hazard_vm_i,
              hazard_vd:  hazard_vd_i
            };
            // Request stays on the port until the answer
            if (needs_answer) state_d = WAIT;
          end
        end
      end

      WAIT: begin
        // Memory ops end on the address generator acknowledge
        if ((pe_req_o.unit == UNIT_LOAD || pe_req_o.unit == UNIT_STORE) && addrgen_ack_i) begin
          state_d             = IDLE;
          seq_req_ready_o     = 1'b1;
          seq_resp_valid_o    = 1'b1;
          seq_resp_o.error    = addrgen_error_i;
          seq_resp_o.error_vl = addrgen_error_vl_i;
        end
        // Scalar move ends on the slide unit result
        if (pe_req_o.op == VMVXS && scalar_resp_valid_i) begin
          state_d             = IDLE;
          seq_req_ready_o     = 1'b1;
          seq_resp_valid_o    = 1'b1;
          seq_resp_o.resp     = scalar_resp_i;
          scalar_resp_ready_o = 1'b1;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= IDLE;
      pe_req_valid_o <= 1'b0;
    end else begin
      state_q        <= state_d;
      pe_req_valid_o <= pe_req_valid_d;
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    pe_req_o <= pe_req_d;
  end

  // Back-pressure holds the request until the units take it
  a_pe_req_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (pe_req_valid_o && !pe_req_ready_i) |=> (pe_req_valid_o && $stable(pe_req_o))
  );

endmodule

//--- src/seq_pkg.sv
/*
 * Vector sequencer package
 * Sizes, operation and unit encodings, the operand union and the
 * request and response structs shared by the sequencer blocks
 */
package seq_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Instruction IDs in flight
  localparam int unsigned NrVInsn = 8;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  // Vector register file
  localparam int unsigned NrVRegs = 32;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;

  // One bit per instruction ID
  typedef logic [NrVInsn-1:0] vmask_t;

  // Mask operand always lives in v0
  localparam vreg_t VMaskReg = vreg_t'(0);

  ////////////////////
  // Units
  ////////////////////

  localparam int unsigned NrUnits = 5;

  typedef enum logic [2:0] {
    UNIT_ALU,
    UNIT_MFPU,
    UNIT_LOAD,
    UNIT_STORE,
    UNIT_SLIDE
  } unit_e;

  // Queue depth per unit, indexed by unit_e
  localparam int unsigned UnitQueueDepth [NrUnits] = '{4, 4, 2, 2, 2};

  // Wide enough to hold the deepest queue
  localparam int unsigned CntWidth = 3;

  ////////////////////
  // Operations
  ////////////////////

  // Grouped in ranges by unit
  typedef enum logic [3:0] {
    VADD       = 4'd0,
    VSUB       = 4'd1,
    VAND       = 4'd2,
    VMUL       = 4'd3,
    VFADD      = 4'd4,
    VLE        = 4'd5,
    VSE        = 4'd6,
    VSLIDEUP   = 4'd7,
    VSLIDEDOWN = 4'd8,
    VMVXS      = 4'd9
  } op_e;

  // Unit that executes an op; the scalar move runs on the slide unit
  function automatic unit_e unit_of(op_e op);
    unit_of = UNIT_ALU;
    case (op) inside
      [VADD:VAND]      : unit_of = UNIT_ALU;
      [VMUL:VFADD]     : unit_of = UNIT_MFPU;
      VLE              : unit_of = UNIT_LOAD;
      VSE              : unit_of = UNIT_STORE;
      [VSLIDEUP:VMVXS] : unit_of = UNIT_SLIDE;
      default          : unit_of = UNIT_ALU;
    endcase
  endfunction

  ////////////////////
  // Requests
  ////////////////////

  // Register reading of the operand word
  typedef struct packed {
    logic [15-$bits(vreg_t):0] pad;
    vreg_t                     vs1;
  } vs1_field_t;

  // Either vs1 or a scalar immediate, chosen by use_scalar
  typedef union packed {
    vs1_field_t         vreg;
    logic signed [15:0] imm;
  } operand_u;

  typedef struct packed {
    op_e      op;
    vreg_t    vd;
    logic     use_vd;
    vreg_t    vs2;
    logic     use_vs2;
    operand_u operand;
    logic     use_vs1;
    logic     use_scalar;
    logic     vm;
  } seq_req_t;

  typedef struct packed {
    vid_t     id;
    op_e      op;
    unit_e    unit;
    vreg_t    vd;
    logic     use_vd;
    vreg_t    vs2;
    logic     use_vs2;
    operand_u operand;
    logic     use_vs1;
    logic     use_scalar;
    logic     vm;
    vmask_t   hazard_vs1;
    vmask_t   hazard_vs2;
    vmask_t   hazard_vm;
    vmask_t   hazard_vd;
  } pe_req_t;

  typedef struct packed {
    logic [31:0] resp;
    logic        error;
    logic [15:0] error_vl;
  } seq_resp_t;

endpackage

//--- src/unit_queue_counters.sv
/*
 * Unit queue counters
 * One occupancy counter per processing unit, counted up at issue and
 * down at done, with a room flag per unit
 */
`timescale 1ns/1ps

module unit_queue_counters (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   issue_i,
  input  seq_pkg::unit_e                         issue_unit_i,
  input  seq_pkg::vmask_t [seq_pkg::NrUnits-1:0] pe_done_i,
  output logic [seq_pkg::NrUnits-1:0]            unit_room_o
);
  import seq_pkg::*;

  logic [NrUnits-1:0][CntWidth-1:0] cnt_q;
  logic [NrUnits-1:0]               cnt_up, cnt_down;

  for (genvar u = 0; u < NrUnits; u++) begin : gen_cnt
    assign cnt_up[u]   = issue_i & (issue_unit_i == unit_e'(u));
    // Any finished ID frees one slot
    assign cnt_down[u] = |pe_done_i[u];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[u] <= '0;
      end else if (cnt_up[u] && !cnt_down[u]) begin
        cnt_q[u] <= cnt_q[u] + CntWidth'(1);
      end else if (cnt_down[u] && !cnt_up[u]) begin
        cnt_q[u] <= cnt_q[u] - CntWidth'(1);
      end
    end

    assign unit_room_o[u] = cnt_q[u] < CntWidth'(UnitQueueDepth[u]);

    // Units report done only for IDs they were given
    a_no_underflow : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (cnt_down[u] && !cnt_up[u]) |-> (cnt_q[u] != '0)
    );

    // Issue is held back while a queue is full
    a_no_overflow : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      cnt_q[u] <= CntWidth'(UnitQueueDepth[u])
    );
  end

endmodule

//--- src/vector_sequencer.sv
/*
 * Vector sequencer top
 * ID tracking, hazard checking, unit queue counters and the issue FSM
 */
`timescale 1ns/1ps

module vector_sequencer (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Dispatcher
  input  seq_pkg::seq_req_t                      seq_req_i,
  input  logic                                   seq_req_valid_i,
  output logic                                   seq_req_ready_o,
  output seq_pkg::seq_resp_t                     seq_resp_o,
  output logic                                   seq_resp_valid_o,
  // Processing units
  output seq_pkg::pe_req_t                       pe_req_o,
  output logic                                   pe_req_valid_o,
  input  logic                                   pe_req_ready_i,
  input  seq_pkg::vmask_t [seq_pkg::NrUnits-1:0] pe_done_i,
  // Address generator
  input  logic                                   addrgen_ack_i,
  input  logic                                   addrgen_error_i,
  input  logic [15:0]                            addrgen_error_vl_i,
  // Scalar response
  input  logic [31:0]                            scalar_resp_i,
  input  logic                                   scalar_resp_valid_i,
  output logic                                   scalar_resp_ready_o,
  // Status
  output logic                                   seq_idle_o,
  output seq_pkg::vmask_t                        running_o,
  output seq_pkg::vmask_t [seq_pkg::NrVInsn-1:0] global_hazard_table_o
);
  import seq_pkg::*;

  logic               issue;
  vid_t               issue_vid;
  unit_e              issue_unit;
  vid_t               next_vid;
  logic               vid_full;
  vmask_t             running_next;
  vmask_t             hazard_vs1, hazard_vs2, hazard_vm, hazard_vd;
  logic [NrUnits-1:0] unit_room;

  vid_tracker u_vid_tracker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_i        (issue),
    .issue_vid_i    (issue_vid),
    .issue_unit_i   (issue_unit),
    .pe_done_i      (pe_done_i),
    .next_vid_o     (next_vid),
    .vid_full_o     (vid_full),
    .running_o      (running_o),
    .running_next_o (running_next),
    .idle_o         (seq_idle_o)
  );

  vreg_hazard_checker u_hazard_checker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (seq_req_i),
    .issue_i        (issue),
    .issue_vid_i    (issue_vid),
    .running_i      (running_o),
    .running_next_i (running_next),
    .hazard_vs1_o   (hazard_vs1),
    .hazard_vs2_o   (hazard_vs2),
    .hazard_vm_o    (hazard_vm),
    .hazard_vd_o    (hazard_vd),
    .hazard_table_o (global_hazard_table_o)
  );

  unit_queue_counters u_queue_counters (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_i      (issue),
    .issue_unit_i (issue_unit),
    .pe_done_i    (pe_done_i),
    .unit_room_o  (unit_room)
  );

  issue_fsm u_issue_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .seq_req_i           (seq_req_i),
    .seq_req_valid_i     (seq_req_valid_i),
    .seq_req_ready_o     (seq_req_ready_o),
    .seq_resp_o          (seq_resp_o),
    .seq_resp_valid_o    (seq_resp_valid_o),
    .pe_req_o            (pe_req_o),
    .pe_req_valid_o      (pe_req_valid_o),
    .pe_req_ready_i      (pe_req_ready_i),
    .hazard_vs1_i        (hazard_vs1),
    .hazard_vs2_i        (hazard_vs2),
    .hazard_vm_i         (hazard_vm),
    .hazard_vd_i         (hazard_vd),
    .next_vid_i          (next_vid),
    .vid_full_i          (vid_full),
    .unit_room_i         (unit_room),
    .issue_o             (issue),
    .issue_vid_o         (issue_vid),
    .issue_unit_o        (issue_unit),
    .addrgen_ack_i       (addrgen_ack_i),
    .addrgen_error_i     (addrgen_error_i),
    .addrgen_error_vl_i  (addrgen_error_vl_i),
    .scalar_resp_i       (scalar_resp_i),
    .scalar_resp_valid_i (scalar_resp_valid_i),
    .scalar_resp_ready_o (scalar_resp_ready_o)
  );

endmodule

//--- src/vid_tracker.sv
/*
 * Instruction ID tracker
 * Hands out the lowest free ID and keeps one running matrix per unit
 */
`timescale 1ns/1ps

module vid_tracker (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   issue_i,
  input  seq_pkg::vid_t                          issue_vid_i,
  input  seq_pkg::unit_e                         issue_unit_i,
  input  seq_pkg::vmask_t [seq_pkg::NrUnits-1:0] pe_done_i,
  output seq_pkg::vid_t                          next_vid_o,
  output logic                                   vid_full_o,
  output seq_pkg::vmask_t                        running_o,
  output seq_pkg::vmask_t                        running_next_o,
  output logic                                   idle_o
);
  import seq_pkg::*;

  // Row per unit, column per ID
  vmask_t [NrUnits-1:0] running_d, running_q;

  always_comb begin
    running_d      = running_q;
    running_o      = '0;
    running_next_o = '0;
    // Done bits retire IDs on their unit
    for (int u = 0; u < NrUnits; u++) begin
      running_d[u] &= ~pe_done_i[u];
    end
    if (issue_i) begin
      running_d[issue_unit_i][issue_vid_i] = 1'b1;
    end
    for (int u = 0; u < NrUnits; u++) begin
      running_o      |= running_q[u];
      running_next_o |= running_d[u];
    end
  end

  // Lowest ID that is not running
  always_comb begin
    next_vid_o = '0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!running_o[i]) next_vid_o = vid_t'(i);
    end
  end

  assign vid_full_o = &running_o;
  assign idle_o     = ~|running_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= '0;
    end else begin
      running_q <= running_d;
    end
  end

  // The FSM must never issue without a free ID
  a_no_issue_when_full : assert property (
    @(posedge clk_i) disable iff (!rst_ni) issue_i |-> !vid_full_o
  );

endmodule

//--- src/vreg_hazard_checker.sv
/*
 * Vector register hazard checker
 * Tracks the last reader and writer of every register, derives the
 * RAW, WAR and WAW hazard vectors of the current request and keeps
 * the global hazard table
 */
`timescale 1ns/1ps

module vreg_hazard_checker (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  seq_pkg::seq_req_t                      req_i,
  input  logic                                   issue_i,
  input  seq_pkg::vid_t                          issue_vid_i,
  input  seq_pkg::vmask_t                        running_i,
  input  seq_pkg::vmask_t                        running_next_i,
  output seq_pkg::vmask_t                        hazard_vs1_o,
  output seq_pkg::vmask_t                        hazard_vs2_o,
  output seq_pkg::vmask_t                        hazard_vm_o,
  output seq_pkg::vmask_t                        hazard_vd_o,
  output seq_pkg::vmask_t [seq_pkg::NrVInsn-1:0] hazard_table_o
);
  import seq_pkg::*;

  // Last accessing instruction of a register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_entry_t;

  vreg_entry_t [NrVRegs-1:0] read_list_d, read_list_q;
  vreg_entry_t [NrVRegs-1:0] write_list_d, write_list_q;
  vmask_t [NrVInsn-1:0]      table_d, table_q;

  logic   vs1_is_reg;
  vreg_t  vs1_idx;
  vmask_t war_hazard;

  // One-hot of the entry's ID, only while that ID still runs
  function automatic vmask_t live_mask(vreg_entry_t e, vmask_t running);
    live_mask        = '0;
    live_mask[e.vid] = e.valid & running[e.vid];
  endfunction

  ////////////////////
  // Hazards
  ////////////////////

  // Operand word is a register index only without a scalar
  assign vs1_is_reg = req_i.use_vs1 & ~req_i.use_scalar;
  assign vs1_idx    = req_i.operand.vreg.vs1;

  always_comb begin
    // WAR on vd stalls every source read
    war_hazard = req_i.use_vd ? live_mask(read_list_q[req_i.vd], running_i) : '0;
    // RAW per source, plus WAR
    hazard_vs1_o = war_hazard;
    hazard_vs2_o = war_hazard;
    hazard_vm_o  = war_hazard;
    if (vs1_is_reg) hazard_vs1_o |= live_mask(write_list_q[vs1_idx], running_i);
    if (req_i.use_vs2) hazard_vs2_o |= live_mask(write_list_q[req_i.vs2], running_i);
    if (!req_i.vm) hazard_vm_o |= live_mask(write_list_q[VMaskReg], running_i);
    // WAW
    hazard_vd_o = req_i.use_vd ? live_mask(write_list_q[req_i.vd], running_i) : '0;
  end

  ////////////////////
  // List and table update
  ////////////////////

  always_comb begin
    read_list_d  = read_list_q;
    write_list_d = write_list_q;
    table_d      = table_q;
    // Retire entries of finished IDs
    for (int v = 0; v < NrVRegs; v++) begin
      read_list_d[v].valid  = read_list_q[v].valid & running_i[read_list_q[v].vid];
      write_list_d[v].valid = write_list_q[v].valid & running_i[write_list_q[v].vid];
    end
    if (issue_i) begin
      if (req_i.use_vd) write_list_d[req_i.vd] = '{vid: issue_vid_i, valid: 1'b1};
      if (vs1_is_reg) read_list_d[vs1_idx] = '{vid: issue_vid_i, valid: 1'b1};
      if (req_i.use_vs2) read_list_d[req_i.vs2] = '{vid: issue_vid_i, valid: 1'b1};
      if (!req_i.vm) read_list_d[VMaskReg] = '{vid: issue_vid_i, valid: 1'b1};
      // New row depends on everything it waits for
      table_d[issue_vid_i] = hazard_vs1_o | hazard_vs2_o | hazard_vm_o | hazard_vd_o;
    end
    // Drop dependencies on IDs that are done
    for (int id = 0; id < NrVInsn; id++) begin
      table_d[id] &= running_next_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_list_q  <= '0;
      write_list_q <= '0;
      table_q      <= '0;
    end else begin
      read_list_q  <= read_list_d;
      write_list_q <= write_list_d;
      table_q      <= table_d;
    end
  end

  assign hazard_table_o = table_q;

endmodule
